//--- hw/feSettings.svh
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

////////////////////////////////////////
// Diagnostic strobe timing
////////////////////////////////////////

// Cycles the diag strobe stays high
`define DIAG_HOLD 10
// Idle cycles after the strobe falls
`define DIAG_GAP 4

// Most single steps taken to clear A CHANGE COMING
`define MBOX_SYNC_TRIES 5

////////////////////////////////////////
// Word geometry
////////////////////////////////////////

// Full machine word
`define WORD_W 36
// Half word, also the address width
`define HALF_W 18

`endif

//--- hw/diagPkg.sv
`default_nettype none

package diagPkg;

  ////////////////////////////////////////
  // Diagnostic function codes (octal)
  ////////////////////////////////////////

  // Code on ds is valid only while diagStrobe is high
  typedef enum logic [6:0] {
    diagfStopClock              = 7'o000,
    diagfStartClock             = 7'o001,
    diagfStepClock              = 7'o002,
    diagfCondStep               = 7'o004,
    diagfSetReset               = 7'o006,
    diagfClrReset               = 7'o007,
    diagfClrRun                 = 7'o010,
    diagfClrBurstCtrRh          = 7'o042,
    diagfClrBurstCtrLh          = 7'o043,
    diagfClrClkSrcRate          = 7'o044,
    diagfSetEboxClkDisables     = 7'o045,
    diagfResetParRegs           = 7'o046,
    diagfClrMboxDisParChkErrStop = 7'o047,
    diagfEnableKl               = 7'o067,
    diagfInitChannels           = 7'o070,
    diagfWriteMbox              = 7'o071,
    diagfEbusLoad               = 7'o076
  } tDiagFunc;

  // Reset table entry kinds
  // opSync expands into the bounded MBOX step loop
  typedef enum logic [1:0] {
    opFunc,
    opWrite,
    opSync,
    opEnd
  } tSeqOp;

endpackage

`default_nettype wire

//--- hw/bootPkg.sv
`default_nettype none

`include "feSettings.svh"

package bootPkg;

  ////////////////////////////////////////
  // Bootstrap loader types
  ////////////////////////////////////////

  // Loader parse state
  // ldHeader expects an IOWD or the start word
  // ldData consumes the words of one IOWD block
  typedef enum logic [1:0] {
    ldHeader,
    ldData,
    ldDone
  } tLoadState;

  // Addresses, word counts and EBUS right half
  typedef logic [`HALF_W-1:0] tHalfWord;

endpackage

`default_nettype wire

//--- hw/diagStrober.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module diagStrober import diagPkg::*, bootPkg::*; (
  input  logic     CLK,
  input  logic     reset,
  input  logic     issue,
  input  tDiagFunc func,
  input  tHalfWord writeData,
  input  logic     isWrite,
  output tDiagFunc ds,
  output logic     diagStrobe,
  output tHalfWord dataRH,
  output logic     dataDrive,
  output logic     strobeDone
);

  // Latched request, held for the whole strobe
  tDiagFunc reqFunc;
  tHalfWord reqData;
  logic     reqWrite;

  // Hold and gap counters, count down to zero
  logic [$clog2(`DIAG_HOLD+1)-1:0] holdCnt;
  logic [$clog2(`DIAG_GAP+1)-1:0]  gapCnt;
  logic inGap;

  ////////////////////////////////////////
  // Strobe timing
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      diagStrobe <= 1'b0;
      inGap <= 1'b0;
      holdCnt <= '0;
      gapCnt <= '0;
    end else if (diagStrobe) begin
      // Hold window, last cycle when holdCnt hits zero
      if (holdCnt == '0) begin
        diagStrobe <= 1'b0;
        inGap <= 1'b1;
        gapCnt <= ($bits(gapCnt))'(`DIAG_GAP - 1);
      end else begin
        holdCnt <= holdCnt - 1'b1;
      end
    end else if (inGap) begin
      if (gapCnt == '0)
        inGap <= 1'b0;
      else
        gapCnt <= gapCnt - 1'b1;
    end else if (issue) begin
      // Strobe goes high the cycle after issue
      diagStrobe <= 1'b1;
      holdCnt <= ($bits(holdCnt))'(`DIAG_HOLD - 1);
    end
  end

  // Request payload
  always_ff @(posedge CLK) begin
    if (issue && !diagStrobe && !inGap) begin
      reqFunc <= func;
      reqData <= writeData;
      reqWrite <= isWrite;
    end
  end

  // Done in the last gap cycle
  assign strobeDone = inGap && (gapCnt == '0);

  // EBUS is driven during the hold window only
  assign ds = diagStrobe ? reqFunc : diagfStopClock;
  assign dataDrive = diagStrobe && reqWrite;
  assign dataRH = dataDrive ? reqData : '0;

endmodule

`default_nettype wire

//--- hw/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module resetSequencer import diagPkg::*, bootPkg::*; (
  input  logic     CLK,
  input  logic     reset,
  input  logic     startMaster,
  input  logic     startSoft,
  input  logic     aChangeComing,
  input  logic     strobeDone,
  output logic     issue,
  output tDiagFunc func,
  output tHalfWord writeData,
  output logic     isWrite,
  output logic     seqBusy,
  output logic     seqDone,
  output logic     syncFail
);

  logic       tableSel;   // High selects the master table
  logic [4:0] step;
  logic       dispatch;   // Current entry is evaluated this cycle
  logic [2:0] tries;      // MBOX single steps taken so far
  logic [8:0] ent;        // {op, func} of the current entry
  tSeqOp      entOp;
  logic       syncStep;

  ////////////////////////////////////////
  // Function tables
  ////////////////////////////////////////

  always_comb begin
    ent = {opEnd, diagfStopClock};
    if (tableSel) begin
      // Master reset, phase 1, sync loop, phase 2
      case (step)
        5'd0:  ent = {opFunc,  diagfClrRun};
        5'd1:  ent = {opWrite, diagfClrClkSrcRate};
        5'd2:  ent = {opFunc,  diagfStopClock};
        5'd3:  ent = {opFunc,  diagfSetReset};
        5'd4:  ent = {opWrite, diagfResetParRegs};
        5'd5:  ent = {opWrite, diagfClrMboxDisParChkErrStop};
        5'd6:  ent = {opWrite, diagfClrBurstCtrRh};
        5'd7:  ent = {opWrite, diagfClrBurstCtrLh};
        5'd8:  ent = {opWrite, diagfSetEboxClkDisables};
        5'd9:  ent = {opFunc,  diagfStartClock};
        5'd10: ent = {opWrite, diagfInitChannels};
        5'd11: ent = {opWrite, diagfClrBurstCtrRh};
        5'd12: ent = {opSync,  diagfStepClock};
        5'd13: ent = {opFunc,  diagfCondStep};
        5'd14: ent = {opFunc,  diagfClrReset};
        5'd15: ent = {opWrite, diagfEnableKl};
        5'd16: ent = {opWrite, diagfEbusLoad};
        5'd17: ent = {opWrite, diagfWriteMbox};
        default: ent = {opEnd, diagfStopClock};
      endcase
    end else begin
      // Soft reset for RAM loaders
      case (step)
        5'd0:  ent = {opFunc, diagfSetReset};
        5'd1:  ent = {opFunc, diagfStartClock};
        5'd2:  ent = {opFunc, diagfStopClock};
        5'd3:  ent = {opFunc, diagfCondStep};
        5'd4:  ent = {opFunc, diagfClrReset};
        default: ent = {opEnd, diagfStopClock};
      endcase
    end
  end

  assign entOp = tSeqOp'(ent[8:7]);
  assign func = tDiagFunc'(ent[6:0]);
  assign isWrite = (entOp == opWrite);
  // Only the M-BOX write carries data
  assign writeData = (func == diagfWriteMbox) ? tHalfWord'(18'o120) : '0;

  // Another step while A CHANGE COMING is up and tries remain
  assign syncStep = (entOp == opSync) && aChangeComing && (tries < `MBOX_SYNC_TRIES);
  assign issue = dispatch && ((entOp == opFunc) || (entOp == opWrite) || syncStep);

  ////////////////////////////////////////
  // Table walk
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      seqBusy <= 1'b0;
      seqDone <= 1'b0;
      syncFail <= 1'b0;
      dispatch <= 1'b0;
      tableSel <= 1'b0;
      step <= '0;
      tries <= '0;
    end else begin
      seqDone <= 1'b0;
      if (!seqBusy) begin
        // Master wins if both start together
        if (startMaster || startSoft) begin
          seqBusy <= 1'b1;
          tableSel <= startMaster;
          step <= '0;
          tries <= '0;
          syncFail <= 1'b0;
          dispatch <= 1'b1;
        end
      end else if (dispatch) begin
        case (entOp)
          opFunc, opWrite: dispatch <= 1'b0;
          opSync: begin
            if (syncStep) begin
              tries <= tries + 1'b1;
              dispatch <= 1'b0;
            end else begin
              // Still set here means the step budget ran out
              if (aChangeComing)
                syncFail <= 1'b1;
              step <= step + 5'd1;
            end
          end
          opEnd: begin
            seqBusy <= 1'b0;
            seqDone <= 1'b1;
            dispatch <= 1'b0;
          end
        endcase
      end else if (strobeDone) begin
        // Sync entry is re-evaluated after each step
        dispatch <= 1'b1;
        if (entOp != opSync)
          step <= step + 5'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bootWordPacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module bootWordPacker (
  input  logic              CLK,
  input  logic              reset,
  input  logic              byteValid,
  input  logic [7:0]        byteData,
  output logic              wordValid,
  output logic [`WORD_W-1:0] word
);

  // First four bytes give the top 32 bits
  logic [`WORD_W-5:0] acc;
  logic [2:0] byteCnt;

  ////////////////////////////////////////
  // Five-byte file word assembly
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      byteCnt <= '0;
      wordValid <= 1'b0;
    end else begin
      wordValid <= 1'b0;
      if (byteValid) begin
        if (byteCnt == 3'd4) begin
          byteCnt <= '0;
          wordValid <= 1'b1;
        end else begin
          byteCnt <= byteCnt + 3'd1;
        end
      end
    end
  end

  // Payload shift, MSB first
  always_ff @(posedge CLK) begin
    if (byteValid) begin
      if (byteCnt == 3'd4)
        // Fifth byte supplies only its upper nibble
        word <= {acc, byteData[7:4]};
      else
        acc <= {acc[`WORD_W-13:0], byteData};
    end
  end

endmodule

`default_nettype wire

//--- hw/iowdLoader.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module iowdLoader import bootPkg::*; (
  input  logic               CLK,
  input  logic               reset,
  input  logic               wordValid,
  input  logic [`WORD_W-1:0] word,
  output logic               memWrite,
  output tHalfWord           memAddr,
  output logic [`WORD_W-1:0] memData,
  output logic               loadDone,
  output logic [`WORD_W-1:0] startWord,
  output tHalfWord           minAddr,
  output tHalfWord           maxAddr
);

  tLoadState state;
  tHalfWord  count;   // Words left in the current block
  tHalfWord  addr;    // Next data address
  tHalfWord  lh;
  tHalfWord  rh;

  assign lh = word[`WORD_W-1:`HALF_W];
  assign rh = word[`HALF_W-1:0];

  ////////////////////////////////////////
  // IOWD parse
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= ldHeader;
      memWrite <= 1'b0;
      loadDone <= 1'b0;
      minAddr <= '1;
      maxAddr <= '0;
      count <= '0;
      addr <= '0;
    end else begin
      memWrite <= 1'b0;
      loadDone <= (state == ldDone);
      if (wordValid) begin
        case (state)
          ldHeader: begin
            if (lh >= 18'o400000) begin
              // Negative count in the left half
              count <= ~lh + 1'b1;
              addr <= rh;
              state <= ldData;
            end else begin
              // Start word, also copied to location 0
              memWrite <= 1'b1;
              state <= ldDone;
            end
          end
          ldData: begin
            memWrite <= 1'b1;
            if (addr < minAddr)
              minAddr <= addr;
            if (addr > maxAddr)
              maxAddr <= addr;
            addr <= addr + 1'b1;
            count <= count - 1'b1;
            if (count == 18'd1)
              state <= ldHeader;
          end
          default: ;  // ldDone ignores the rest of the stream
        endcase
      end
    end
  end

  // Write payload
  always_ff @(posedge CLK) begin
    if (wordValid && state == ldData) begin
      memAddr <= addr;
      memData <= word;
    end else if (wordValid && state == ldHeader && lh < 18'o400000) begin
      memAddr <= '0;
      memData <= word;
      startWord <= word;
    end
  end

endmodule

`default_nettype wire

//--- hw/frontEnd.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module frontEnd import diagPkg::*, bootPkg::*; (
  input  logic               CLK,
  input  logic               reset,
  input  logic               startMaster,
  input  logic               startSoft,
  input  logic               aChangeComing,
  input  logic               byteValid,
  input  logic [7:0]         byteData,
  output tDiagFunc           ds,
  output logic               diagStrobe,
  output tHalfWord           dataRH,
  output logic               dataDrive,
  output logic               seqBusy,
  output logic               seqDone,
  output logic               syncFail,
  output logic               memWrite,
  output tHalfWord           memAddr,
  output logic [`WORD_W-1:0] memData,
  output logic               loadDone,
  output logic [`WORD_W-1:0] startWord,
  output tHalfWord           minAddr,
  output tHalfWord           maxAddr
);

  ////////////////////////////////////////
  // Reset sequencing over the EBUS
  ////////////////////////////////////////

  // Sequencer to strober request
  logic     issue;
  tDiagFunc func;
  tHalfWord writeData;
  logic     isWrite;
  logic     strobeDone;

  // Packer to loader
  logic               wordValid;
  logic [`WORD_W-1:0] word;

  resetSequencer seq (
    .CLK, .reset, .startMaster, .startSoft, .aChangeComing, .strobeDone,
    .issue, .func, .writeData, .isWrite, .seqBusy, .seqDone, .syncFail
  );

  diagStrober strober (
    .CLK, .reset, .issue, .func, .writeData, .isWrite,
    .ds, .diagStrobe, .dataRH, .dataDrive, .strobeDone
  );

  // Bootstrap image path
  bootWordPacker packer (
    .CLK, .reset, .byteValid, .byteData, .wordValid, .word
  );

  iowdLoader loader (
    .CLK, .reset, .wordValid, .word,
    .memWrite, .memAddr, .memData, .loadDone, .startWord, .minAddr, .maxAddr
  );

endmodule

`default_nettype wire

//--- tb/frontEndTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "feSettings.svh"

module frontEndTb import diagPkg::*, bootPkg::*; ();

  localparam int NUM_ENT = 6;
  localparam int KIND_MASTER = 0;
  localparam int KIND_SOFT = 1;
  localparam int KIND_LOAD = 2;
  localparam int FUNC_CYCLES = 1 + `DIAG_HOLD + `DIAG_GAP;

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  int entKind [NUM_ENT] = '{KIND_MASTER, KIND_MASTER, KIND_MASTER, KIND_MASTER,
                            KIND_SOFT, KIND_LOAD};
  // Step strobes after which the MBOX drops A CHANGE COMING
  int entSteps [NUM_ENT] = '{0, 2, 5, 7, 0, 0};
  int entBlocks [NUM_ENT] = '{0, 0, 0, 0, 0, 3};
  // Block lengths, random, filled in at start
  int entLens [NUM_ENT][4];

  // DUT inputs
  logic       CLK;
  logic       reset;
  logic       startMaster;
  logic       startSoft;
  logic       aChangeComing = 1'b0;
  logic       byteValid;
  logic [7:0] byteData;

  // DUT outputs
  tDiagFunc    ds;
  logic        diagStrobe;
  tHalfWord    dataRH;
  logic        dataDrive;
  logic        seqBusy;
  logic        seqDone;
  logic        syncFail;
  logic        memWrite;
  tHalfWord    memAddr;
  logic [35:0] memData;
  logic        loadDone;
  logic [35:0] startWord;
  tHalfWord    minAddr;
  tHalfWord    maxAddr;

  // Observed strobes, appended by the monitor
  logic [6:0] obsFunc [$];
  logic       obsDrive [$];
  tHalfWord   obsData [$];
  // Expected strobes of the current entry
  logic [6:0] expFunc [$];
  logic       expDrive [$];
  tHalfWord   expData [$];
  // Expected memory writes, in order
  tHalfWord    wrAddr [$];
  logic [35:0] wrData [$];

  int errCount = 0;
  int checkCount = 0;
  int limitCycles = 0;
  int stepTotal = 0;
  int doneTotal = 0;
  int writeIdx = 0;
  int stepBase = 0;
  int mboxTarget = 0;
  int highCnt = 0;
  int lowCnt = 0;
  logic prevStrobe = 1'b0;
  logic seenFall = 1'b0;

  frontEnd i_dut (
    .CLK(CLK), .reset(reset), .startMaster(startMaster), .startSoft(startSoft),
    .aChangeComing(aChangeComing), .byteValid(byteValid), .byteData(byteData),
    .ds(ds), .diagStrobe(diagStrobe), .dataRH(dataRH), .dataDrive(dataDrive),
    .seqBusy(seqBusy), .seqDone(seqDone), .syncFail(syncFail),
    .memWrite(memWrite), .memAddr(memAddr), .memData(memData), .loadDone(loadDone),
    .startWord(startWord), .minAddr(minAddr), .maxAddr(maxAddr)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic compareValue(input logic [35:0] got, input logic [35:0] exp,
                              input string what);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Strobe monitor and MBOX model
  ////////////////////////////////////////

  always @(posedge CLK) begin
    if (reset) begin
      prevStrobe <= 1'b0;
      seenFall <= 1'b0;
    end else begin
      prevStrobe <= diagStrobe;
      if (diagStrobe && !prevStrobe) begin
        // Record the bus at the strobe's first cycle
        obsFunc.push_back(ds);
        obsDrive.push_back(dataDrive);
        obsData.push_back(dataRH);
        if (ds == diagfStepClock)
          stepTotal <= stepTotal + 1;
        highCnt <= 1;
        if (seenFall) begin
          checkCount++;
          assert (lowCnt >= `DIAG_GAP + 1) else begin
            errCount++;
            $display("error %0t: strobe gap of %0d cycles is too short", $time, lowCnt);
          end
        end
      end else if (diagStrobe) begin
        highCnt <= highCnt + 1;
      end
      if (!diagStrobe && prevStrobe) begin
        compareValue(highCnt, `DIAG_HOLD, "strobe high time");
        seenFall <= 1'b1;
        lowCnt <= 1;
      end else if (!diagStrobe) begin
        lowCnt <= lowCnt + 1;
      end
      if (seqDone)
        doneTotal <= doneTotal + 1;
    end
  end

  // A CHANGE COMING clears after the armed number of step strobes
  always @(posedge CLK) begin
    aChangeComing <= (stepTotal - stepBase) < mboxTarget;
  end

  // Memory scoreboard
  always @(posedge CLK) begin
    if (!reset && memWrite) begin
      checkCount++;
      assert (writeIdx < wrAddr.size()) else begin
        errCount++;
        $display("error %0t: memWrite to %0o with no write expected", $time, memAddr);
      end
      if (writeIdx < wrAddr.size()) begin
        compareValue(memAddr, wrAddr[writeIdx], "memAddr");
        compareValue(memData, wrData[writeIdx], "memData");
      end
      writeIdx <= writeIdx + 1;
    end
  end

  ////////////////////////////////////////
  // Reset sequence entries
  ////////////////////////////////////////

  task automatic pushExp(input tDiagFunc f, input logic w, input tHalfWord d);
    expFunc.push_back(f);
    expDrive.push_back(w);
    expData.push_back(d);
  endtask

  task automatic runReset(input int e);
    logic master;
    int stepsExp;
    int logBase;
    int doneBase;
    master = (entKind[e] == KIND_MASTER);
    stepsExp = (entSteps[e] < `MBOX_SYNC_TRIES) ? entSteps[e] : `MBOX_SYNC_TRIES;
    expFunc.delete();
    expDrive.delete();
    expData.delete();
    if (master) begin
      pushExp(diagfClrRun, 1'b0, '0);
      pushExp(diagfClrClkSrcRate, 1'b1, '0);
      pushExp(diagfStopClock, 1'b0, '0);
      pushExp(diagfSetReset, 1'b0, '0);
      pushExp(diagfResetParRegs, 1'b1, '0);
      pushExp(diagfClrMboxDisParChkErrStop, 1'b1, '0);
      pushExp(diagfClrBurstCtrRh, 1'b1, '0);
      pushExp(diagfClrBurstCtrLh, 1'b1, '0);
      pushExp(diagfSetEboxClkDisables, 1'b1, '0);
      pushExp(diagfStartClock, 1'b0, '0);
      pushExp(diagfInitChannels, 1'b1, '0);
      pushExp(diagfClrBurstCtrRh, 1'b1, '0);
      // MBOX sync loop
      for (int i = 0; i < stepsExp; i++)
        pushExp(diagfStepClock, 1'b0, '0);
      pushExp(diagfCondStep, 1'b0, '0);
      pushExp(diagfClrReset, 1'b0, '0);
      pushExp(diagfEnableKl, 1'b1, '0);
      pushExp(diagfEbusLoad, 1'b1, '0);
      pushExp(diagfWriteMbox, 1'b1, 18'o120);
    end else begin
      pushExp(diagfSetReset, 1'b0, '0);
      pushExp(diagfStartClock, 1'b0, '0);
      pushExp(diagfStopClock, 1'b0, '0);
      pushExp(diagfCondStep, 1'b0, '0);
      pushExp(diagfClrReset, 1'b0, '0);
    end
    // Arm the MBOX model a few cycles ahead of the start
    stepBase = stepTotal;
    mboxTarget = master ? entSteps[e] : 0;
    repeat (2) @(posedge CLK);
    logBase = obsFunc.size();
    doneBase = doneTotal;
    if (master)
      startMaster <= 1'b1;
    else
      startSoft <= 1'b1;
    @(posedge CLK);
    startMaster <= 1'b0;
    startSoft <= 1'b0;
    if (!master) begin
      // A master start while busy must be dropped
      repeat (3) @(posedge CLK);
      compareValue(seqBusy, 1'b1, "seqBusy during soft reset");
      startMaster <= 1'b1;
      @(posedge CLK);
      startMaster <= 1'b0;
    end
    while (!seqDone)
      @(posedge CLK);
    repeat (3) @(posedge CLK);
    compareValue(doneTotal - doneBase, 1, "seqDone pulse count");
    compareValue(seqBusy, 1'b0, "seqBusy after seqDone");
    compareValue(syncFail, master && (entSteps[e] > `MBOX_SYNC_TRIES), "syncFail");
    compareValue(stepTotal - stepBase, stepsExp, "step strobe count");
    compareValue(obsFunc.size() - logBase, expFunc.size(), "strobe count");
    for (int i = 0; i < expFunc.size() && logBase + i < obsFunc.size(); i++) begin
      compareValue(obsFunc[logBase+i], expFunc[i], $sformatf("ds of strobe %0d", i));
      compareValue(obsDrive[logBase+i], expDrive[i], $sformatf("dataDrive of strobe %0d", i));
      compareValue(obsData[logBase+i], expData[i], $sformatf("dataRH of strobe %0d", i));
    end
  endtask

  ////////////////////////////////////////
  // Bootstrap image entry
  ////////////////////////////////////////

  task automatic sendByte(input logic [7:0] b);
    @(posedge CLK);
    byteValid <= 1'b1;
    byteData <= b;
    @(posedge CLK);
    byteValid <= 1'b0;
  endtask

  // File word, MSB first, fifth byte carries the low nibble on top
  task automatic sendWord(input logic [35:0] w);
    sendByte(w[35:28]);
    sendByte(w[27:20]);
    sendByte(w[19:12]);
    sendByte(w[11:4]);
    sendByte({w[3:0], 4'($urandom)});
  endtask

  task automatic runLoad(input int e);
    logic [35:0] d;
    tHalfWord base;
    tHalfWord minExp;
    tHalfWord maxExp;
    int writesSeen;
    minExp = '1;
    maxExp = '0;
    for (int b = 0; b < entBlocks[e]; b++) begin
      // Disjoint blocks, clear of location 0
      base = 18'(1 + b * 256 + ($urandom % 200));
      sendWord({18'(262144 - entLens[e][b]), base});
      for (int i = 0; i < entLens[e][b]; i++) begin
        d[35:32] = 4'($urandom);
        d[31:0] = $urandom;
        wrAddr.push_back(base + 18'(i));
        wrData.push_back(d);
        if (base + 18'(i) < minExp)
          minExp = base + 18'(i);
        if (base + 18'(i) > maxExp)
          maxExp = base + 18'(i);
        sendWord(d);
      end
    end
    // Start word has a positive left half
    d = {1'b0, 17'($urandom), 18'($urandom)};
    wrAddr.push_back('0);
    wrData.push_back(d);
    sendWord(d);
    while (!loadDone)
      @(posedge CLK);
    repeat (2) @(posedge CLK);
    compareValue(writeIdx, wrAddr.size(), "memWrite count");
    compareValue(startWord, d, "startWord");
    compareValue(minAddr, minExp, "minAddr");
    compareValue(maxAddr, maxExp, "maxAddr");
    // Trailing words, one shaped like an IOWD
    writesSeen = writeIdx;
    sendWord({18'o777776, 18'o000100});
    sendWord({4'($urandom), $urandom});
    repeat (10) @(posedge CLK);
    compareValue(writeIdx, writesSeen, "memWrite count after loadDone");
    compareValue(loadDone, 1'b1, "loadDone");
  endtask

  // Watchdog budget in strobe slots per entry
  function automatic int slotsFor(input int e);
    int words;
    words = 3;
    if (entKind[e] == KIND_MASTER)
      return 18 + `MBOX_SYNC_TRIES;
    if (entKind[e] == KIND_SOFT)
      return 5;
    for (int b = 0; b < entBlocks[e]; b++)
      words += 1 + entLens[e][b];
    return (words * 10 + FUNC_CYCLES - 1) / FUNC_CYCLES;
  endfunction

  ////////////////////////////////////////
  // Main flow
  ////////////////////////////////////////

  initial begin
    int slots;
    void'($urandom(13));
    reset = 1'b1;
    startMaster = 1'b0;
    startSoft = 1'b0;
    byteValid = 1'b0;
    byteData = 8'h00;
    slots = 0;
    for (int e = 0; e < NUM_ENT; e++) begin
      for (int b = 0; b < 4; b++)
        entLens[e][b] = 1 + ($urandom % 8);
      slots += slotsFor(e);
    end
    limitCycles = slots * FUNC_CYCLES + 500;
    repeat (4) @(posedge CLK);
    reset <= 1'b0;
    repeat (2) @(posedge CLK);
    for (int e = 0; e < NUM_ENT; e++) begin
      if (entKind[e] == KIND_LOAD)
        runLoad(e);
      else
        runReset(e);
    end
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge CLK);
    $display("Timeout: the tests did not finish within %0d clock cycles", limitCycles);
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/diagPkg.sv
hw/bootPkg.sv
hw/diagStrober.sv
hw/resetSequencer.sv
hw/bootWordPacker.sv
hw/iowdLoader.sv
hw/frontEnd.sv
tb/frontEndTb.sv

//--- Bender.yml
package:
  name: kl10_front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/diagPkg.sv
      - hw/bootPkg.sv
      - hw/diagStrober.sv
      - hw/resetSequencer.sv
      - hw/bootWordPacker.sv
      - hw/iowdLoader.sv
      - hw/frontEnd.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/frontEndTb.sv
